// ==== list.f ====
hw/dma_pkg.sv
hw/layer_desc_regs.sv
hw/fmi_tile_walker.sv
hw/kexp_walker.sv
hw/dma_ctrl.sv
hw/dma_top.sv
sim/ext_mem_model.sv
sim/tb_dma_top.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_dma_top
FILELIST  = list.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/tb_dma_top.sv ====
`timescale 1ns/1ps

module tb_dma_top
	import dma_pkg::*;
;

	localparam int DATA_W  = 32;
	localparam int ADDR_W  = 32;
	localparam int RAM_AW  = 12;
	localparam int TIX     = 8;
	localparam int TIY     = 8;
	localparam int KX      = 3;
	localparam int KY      = 3;
	localparam int NPAR    = 4;
	localparam int NNP     = 4;
	localparam int TIMEOUT = 2000; // Cycles per operation

	// Small layer of 5x4 pixels with 2 channels
	localparam int NIX      = 5;
	localparam int NIY      = 4;
	localparam int T        = 3;
	localparam int S        = 1;
	localparam int NIF      = 2;
	localparam int NOF      = 6;
	localparam int NGR      = 3;
	localparam int NGRINT   = 1;
	localparam int IFM_BASE = 32'h100;
	localparam int KEX_BASE = 32'h400;

	localparam logic [31:0] W0 = 32'(NIX + NIY * 256 + T * 65536 + S * 524288);
	localparam logic [31:0] W1 = 32'(NIF + NOF * 4096);
	localparam logic [31:0] W2 = 32'(NGR + NGRINT * 4096);
	localparam logic [255:0] DESC_ALL = {32'h0a00, 32'h0900, 32'(KEX_BASE), 32'h0800,
		32'(IFM_BASE), W2, W1, W0}; // Words 4, 6, 7 unused by the DMA

	localparam logic [63:0] INFO = 64'(NIX) | (64'(NIY) << 8) | (64'(NIF) << 16) |
		(64'(NOF) << 27) | (64'(T) << 38) | (64'(S) << 41) | (64'(NGR) << 42) |
		(64'(NGRINT) << 53);

	logic                   clk, rst;
	logic                   start_i;
	dma_op_t                op_i;
	logic [ADDR_W-1:0]      tx_i, ty_i, x_mem_i, y_mem_i;
	logic                   mem_valid_i;
	logic [DATA_W-1:0]      mem_data_i;
	logic                   mem_req_o;
	logic [ADDR_W-1:0]      mem_addr_o;
	logic                   w_fmi_o, w_kex_o;
	logic [RAM_AW-1:0]      ram_addr_o;
	logic [DATA_W-1:0]      wdata_o;
	logic                   done_o;
	logic [CONV_INFO_W-1:0] conv_info_o;

	// Expected traffic filled when a start is accepted
	logic [31:0]       exp_req[$];
	logic [RAM_AW-1:0] exp_ram[$];
	logic [31:0]       exp_data[$];
	int exp_req_total, exp_wr_total;

	// Monitor state
	int cyc, cur_op, req_cnt, wr_cnt, done_cnt;
	int start_cyc, last_wr_cyc, last_valid_cyc, first_req_cyc;
	logic started, outstanding;
	int mon_errors, seq_errors, timeouts;

	dma_top #(
		.DATA_W(DATA_W), .ADDR_W(ADDR_W), .RAM_AW(RAM_AW), .TIX(TIX), .TIY(TIY),
		.KX(KX), .KY(KY), .NPAR(NPAR), .NNP(NNP)
	) dut_i (
		.clk(clk), .rst(rst), .start_i(start_i), .op_i(op_i),
		.tx_i(tx_i), .ty_i(ty_i), .x_mem_i(x_mem_i), .y_mem_i(y_mem_i),
		.mem_valid_i(mem_valid_i), .mem_data_i(mem_data_i),
		.mem_req_o(mem_req_o), .mem_addr_o(mem_addr_o),
		.w_fmi_o(w_fmi_o), .w_kex_o(w_kex_o), .ram_addr_o(ram_addr_o),
		.wdata_o(wdata_o), .done_o(done_o), .conv_info_o(conv_info_o)
	);

	ext_mem_model #(.DESC_WORDS(DESC_ALL)) mem_i (
		.clk(clk), .rst(rst), .req_i(mem_req_o), .addr_i(mem_addr_o),
		.valid_o(mem_valid_i), .data_o(mem_data_i)
	);

	function automatic int report_fail(input string msg);
		$display("Fail at %0t ns: %s", $time, msg);
		return 1;
	endfunction

	function automatic logic [31:0] expected_word(input logic [31:0] addr);
		if (addr < 32'd8)
			return DESC_ALL[addr[2:0]*32 +: 32];
		return addr ^ 32'h5a5a0000;
	endfunction

	task automatic build_load();
		for (int i = 0; i < 8; i++)
			exp_req.push_back(32'(i)); // Descriptor words in order
	endtask

	// With the tile origin at the image corner pixel (tx, ty) sits at (tx-1, ty-1)
	task automatic build_fmi(input int tx0, input int ty0);
		int ncols, nrows, tx, ty, ram, ext;
		logic pad;
		ncols = NIX + KX / 2 - tx0 + 1; // Up to the right border column
		if (ncols > TIX)
			ncols = TIX;
		nrows = NIY + KY / 2 - ty0 + 1;
		if (nrows > TIY)
			nrows = TIY;
		for (int c = 0; c < NIF; c++) begin
			for (int j = 0; j < nrows; j++) begin
				for (int i = 0; i < ncols; i++) begin
					tx  = tx0 + i;
					ty  = ty0 + j;
					ram = c * TIX * TIY + j * TIX + i;
					pad = (tx == 0) || (ty == 0) || (tx > NIX) || (ty > NIY);
					exp_ram.push_back(RAM_AW'(ram));
					if (pad) begin
						exp_data.push_back('0); // Border pixel without a read
					end else begin
						ext = IFM_BASE + c * NIX * NIY + (ty - 1) * NIX + (tx - 1);
						exp_req.push_back(32'(ext));
						exp_data.push_back(expected_word(32'(ext)));
					end
				end
			end
		end
	endtask

	task automatic build_kexp(input int ch0, input int xm);
		int size, nk, ext;
		size = NGR * NNP;
		nk   = NIF * T - ch0 + 1; // Channels left
		if (nk > NPAR)
			nk = NPAR;
		for (int k = 0; k < nk; k++) begin
			for (int w = 0; w < size; w++) begin
				ext = KEX_BASE + xm + k * size + w;
				exp_req.push_back(32'(ext));
				exp_ram.push_back(RAM_AW'(k * size + w));
				exp_data.push_back(expected_word(32'(ext)));
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Samples at the rising edge the values of the ending cycle
	always @(posedge clk) begin : monitor
		logic [31:0]       a;
		logic [RAM_AW-1:0] r;
		logic [31:0]       d;
		if (rst) begin
			cyc         = 0;
			started     = 1'b0;
			outstanding = 1'b0;
			cur_op      = 0;
			req_cnt     = 0;
			wr_cnt      = 0;
			done_cnt    = 0;
			mon_errors  = 0;
		end else begin
			if (!started)
				assert (!mem_req_o && !w_fmi_o && !w_kex_o && !done_o)
				else mon_errors += report_fail("control output active before first start");
			if (mem_valid_i) begin // Answer handled before any new request
				assert (outstanding)
				else mon_errors += report_fail("mem_valid_i with no request pending");
				outstanding    = 1'b0;
				last_valid_cyc = cyc;
			end
			if (mem_req_o) begin
				assert (!outstanding)
				else mon_errors += report_fail("second request before the answer");
				assert (cur_op <= 2)
				else mon_errors += report_fail("request during an unused opcode");
				if (req_cnt > 0 && cur_op == 0)
					assert (cyc == last_valid_cyc + 2)
					else mon_errors += report_fail("descriptor request out of step");
				if (req_cnt > 0 && (cur_op == 1 || cur_op == 2))
					assert (cyc == last_wr_cyc + 1)
					else mon_errors += report_fail("request not one cycle after strobe");
				if (first_req_cyc < 0)
					first_req_cyc = cyc;
				outstanding = 1'b1;
				req_cnt++;
				assert (exp_req.size() != 0)
				else mon_errors += report_fail("request beyond expected count");
				if (exp_req.size() != 0) begin
					a = exp_req.pop_front();
					assert (mem_addr_o == a)
					else mon_errors += report_fail($sformatf("mem_addr_o %0h, expected %0h",
						mem_addr_o, a));
				end
			end
			if (w_fmi_o || w_kex_o) begin
				assert ((w_fmi_o && cur_op == 1) || (w_kex_o && cur_op == 2))
				else mon_errors += report_fail("write strobe for the wrong operation");
				if (w_kex_o)
					assert (cyc == last_valid_cyc + 1)
					else mon_errors += report_fail("kernel strobe not one cycle after mem_valid_i");
				assert (exp_ram.size() != 0)
				else mon_errors += report_fail("write strobe beyond expected count");
				if (exp_ram.size() != 0) begin
					r = exp_ram.pop_front();
					d = exp_data.pop_front();
					assert (ram_addr_o == r)
					else mon_errors += report_fail($sformatf("ram_addr_o %0h, expected %0h",
						ram_addr_o, r));
					assert (wdata_o == d)
					else mon_errors += report_fail($sformatf("wdata_o %0h at ram %0h, expected %0h",
						wdata_o, r, d));
				end
				wr_cnt++;
				last_wr_cyc = cyc;
			end
			if (done_o) begin
				done_cnt++;
				assert (exp_req.size() == 0)
				else mon_errors += report_fail("done with requests still missing");
				case (cur_op)
					0, 2: begin
						assert (first_req_cyc == start_cyc + 1)
						else mon_errors += report_fail("first request not one cycle after start");
						if (cur_op == 0)
							assert (cyc == last_valid_cyc + 2)
							else mon_errors += report_fail("done not after last descriptor word");
						else
							assert (cyc == last_wr_cyc + 1 && exp_ram.size() == 0)
							else mon_errors += report_fail("done not after final kernel strobe");
					end
					1: assert (cyc == last_wr_cyc + 1 && exp_ram.size() == 0)
						else mon_errors += report_fail("done not after final tile strobe");
					default: assert (cyc == start_cyc + 1 && req_cnt == 0 && wr_cnt == 0)
						else mon_errors += report_fail("unused opcode did not end at once");
				endcase
			end
			if (start_i) begin // Only driven while idle
				started       = 1'b1;
				cur_op        = int'(op_i);
				start_cyc     = cyc;
				first_req_cyc = -1;
				req_cnt       = 0;
				wr_cnt        = 0;
				done_cnt      = 0;
				exp_req.delete();
				exp_ram.delete();
				exp_data.delete();
				case (op_i)
					OP_LOAD_LAYER: build_load();
					OP_FILL_FMI:   build_fmi(int'(tx_i), int'(ty_i));
					OP_FILL_KEXP:  build_kexp(int'(tx_i), int'(x_mem_i));
					default: ;
				endcase
				exp_req_total = exp_req.size();
				exp_wr_total  = exp_ram.size();
			end
			cyc++;
		end
	end

	task automatic run_op(input logic [2:0] op, input logic [31:0] tx, input logic [31:0] xm);
		int n;
		@(negedge clk);
		op_i    = dma_op_t'(op);
		tx_i    = tx;
		ty_i    = '0;
		x_mem_i = xm;
		y_mem_i = '0;
		start_i = 1'b1;
		@(negedge clk);
		start_i = 1'b0;
		n = 0;
		while (done_cnt == 0 && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (done_cnt == 0) begin
			timeouts++;
			$display("Timeout: operation %0d never signalled done", op);
		end else begin
			repeat (3) @(negedge clk); // Room for a stray second pulse
			assert (done_cnt == 1)
			else seq_errors += report_fail($sformatf("op %0d done pulsed %0d times", op, done_cnt));
			assert (req_cnt == exp_req_total)
			else seq_errors += report_fail($sformatf("op %0d made %0d requests, expected %0d",
				op, req_cnt, exp_req_total));
			assert (wr_cnt == exp_wr_total)
			else seq_errors += report_fail($sformatf("op %0d made %0d strobes, expected %0d",
				op, wr_cnt, exp_wr_total));
		end
	endtask

	initial begin
		rst        = 1'b1;
		start_i    = 1'b0;
		op_i       = OP_LOAD_LAYER;
		tx_i       = '0;
		ty_i       = '0;
		x_mem_i    = '0;
		y_mem_i    = '0;
		seq_errors = 0;
		timeouts   = 0;
		repeat (10) @(negedge clk);
		rst = 1'b0;
		repeat (4) @(negedge clk); // Idle with all strobes low
		run_op(3'd0, 32'd0, 32'd0);
		if (timeouts == 0)
			assert (conv_info_o == INFO)
			else seq_errors += report_fail($sformatf("conv_info_o %0h, expected %0h",
				conv_info_o, INFO));
		if (timeouts == 0)
			run_op(3'd1, 32'd0, 32'd0); // Tile at the corner with padded border
		if (timeouts == 0)
			run_op(3'd2, 32'd4, 32'h20); // Channel limit after 3 kernels
		if (timeouts == 0)
			run_op(3'd2, 32'd1, 32'd0);  // Buffer limit after NPAR kernels
		if (timeouts == 0)
			run_op(3'd5, 32'd0, 32'd0);
		$display("Checks failed: %0d, timeouts: %0d", mon_errors + seq_errors, timeouts);
		if (mon_errors + seq_errors == 0 && timeouts == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== sim/ext_mem_model.sv ====
`timescale 1ns/1ps

module ext_mem_model #(
	parameter logic [255:0] DESC_WORDS = '0,           // Words 0 to 7 with word 0 in the lsbs
	parameter int unsigned  SEED       = 32'h824c3e22,
	parameter int           MAX_DELAY  = 5
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        req_i,
	input  logic [31:0] addr_i,
	output logic        valid_o,
	output logic [31:0] data_o
);

	logic        busy;     // Request taken and answer pending
	logic [31:0] addr_q;
	int          delay;    // Cycles left before the answer

	// Descriptor at the bottom and a pattern of the full address above it
	function automatic logic [31:0] word_at(input logic [31:0] addr);
		if (addr < 32'd8)
			return DESC_WORDS[addr[2:0]*32 +: 32];
		return addr ^ 32'h5a5a0000;
	endfunction

	initial void'($urandom(SEED)); // One seed for the whole run

	// Sampled and driven on the falling edge away from the DUT clock edge
	always @(negedge clk or posedge rst) begin
		if (rst) begin
			busy    <= 1'b0;
			valid_o <= 1'b0;
			data_o  <= '0;
			addr_q  <= '0;
			delay   <= 0;
		end else begin
			valid_o <= 1'b0; // Single cycle pulse
			if (busy) begin
				if (delay == 0) begin
					valid_o <= 1'b1;
					data_o  <= word_at(addr_q);
					busy    <= 1'b0;
				end else begin
					delay <= delay - 1;
				end
			end else if (req_i) begin
				busy   <= 1'b1;
				addr_q <= addr_i;
				delay  <= int'($urandom % (MAX_DELAY + 1)); // 0 to 5 cycles
			end
		end
	end

endmodule

// ==== hw/dma_top.sv ====
`timescale 1ns/1ps

module dma_top
	import dma_pkg::*;
#(
	parameter int DATA_W = 32,
	parameter int ADDR_W = 32,
	parameter int RAM_AW = 12,
	parameter int TIX    = 8,
	parameter int TIY    = 8,
	parameter int KX     = 3,
	parameter int KY     = 3,
	parameter int NPAR   = 4,
	parameter int NNP    = 4
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   start_i,
	input  dma_op_t                op_i,
	input  logic [ADDR_W-1:0]      tx_i,
	input  logic [ADDR_W-1:0]      ty_i,
	input  logic [ADDR_W-1:0]      x_mem_i,
	input  logic [ADDR_W-1:0]      y_mem_i,
	input  logic                   mem_valid_i,
	input  logic [DATA_W-1:0]      mem_data_i,
	output logic                   mem_req_o,
	output logic [ADDR_W-1:0]      mem_addr_o,
	output logic                   w_fmi_o,
	output logic                   w_kex_o,
	output logic [RAM_AW-1:0]      ram_addr_o,
	output logic [DATA_W-1:0]      wdata_o,
	output logic                   done_o,
	output logic [CONV_INFO_W-1:0] conv_info_o
);

	logic                  desc_clr, desc_wr, desc_last;
	logic [DESC_IDX_W-1:0] desc_idx;
	logic [DIM_W-1:0]      nix, niy;
	logic [CH_W-1:0]       nif, ngr;
	logic [EXP_W-1:0]      t;
	logic [DATA_W-1:0]     ifm_base, kex_base; // As read from descriptor
	logic [ADDR_W-1:0]     ifm_base_a, kex_base_a;

	logic                  fmi_start, fmi_step, fmi_last, fmi_pad;
	logic [ADDR_W-1:0]     fmi_ext_addr;
	logic [RAM_AW-1:0]     fmi_ram_addr;
	logic                  kex_start, kex_step, kex_last;
	logic [ADDR_W-1:0]     kex_ext_addr;
	logic [RAM_AW-1:0]     kex_ram_addr;

	// Descriptor words become addresses
	assign ifm_base_a = ADDR_W'(ifm_base);
	assign kex_base_a = ADDR_W'(kex_base);

	dma_ctrl #(.DATA_W(DATA_W), .ADDR_W(ADDR_W), .RAM_AW(RAM_AW)) ctrl_i (
		.clk(clk), .rst(rst),
		.start_i(start_i), .op_i(op_i),
		.mem_valid_i(mem_valid_i), .mem_data_i(mem_data_i),
		.mem_req_o(mem_req_o), .mem_addr_o(mem_addr_o),
		.w_fmi_o(w_fmi_o), .w_kex_o(w_kex_o),
		.ram_addr_o(ram_addr_o), .wdata_o(wdata_o), .done_o(done_o),
		.desc_clr_o(desc_clr), .desc_wr_o(desc_wr),
		.desc_idx_i(desc_idx), .desc_last_i(desc_last),
		.fmi_start_o(fmi_start), .fmi_step_o(fmi_step),
		.fmi_last_i(fmi_last), .fmi_pad_i(fmi_pad),
		.fmi_ext_addr_i(fmi_ext_addr), .fmi_ram_addr_i(fmi_ram_addr),
		.kex_start_o(kex_start), .kex_step_o(kex_step), .kex_last_i(kex_last),
		.kex_ext_addr_i(kex_ext_addr), .kex_ram_addr_i(kex_ram_addr)
	);

	layer_desc_regs #(.DATA_W(DATA_W)) desc_i (
		.clk(clk), .rst(rst),
		.desc_clr_i(desc_clr), .desc_wr_i(desc_wr), .wdata_i(wdata_o),
		.desc_idx_o(desc_idx), .desc_last_o(desc_last),
		.nix_o(nix), .niy_o(niy), .nif_o(nif), .t_o(t), .ngr_o(ngr),
		.ifm_base_o(ifm_base), .kex_base_o(kex_base),
		.conv_info_o(conv_info_o)
	);

	fmi_tile_walker #(
		.ADDR_W(ADDR_W), .RAM_AW(RAM_AW),
		.TIX(TIX), .TIY(TIY), .KX(KX), .KY(KY)
	) fmi_i (
		.clk(clk), .rst(rst),
		.start_i(fmi_start), .step_i(fmi_step),
		.tx_i(tx_i), .ty_i(ty_i), .x_mem_i(x_mem_i), .y_mem_i(y_mem_i),
		.nix_i(nix), .niy_i(niy), .nif_i(nif), .ifm_base_i(ifm_base_a),
		.pad_o(fmi_pad), .last_o(fmi_last),
		.ext_addr_o(fmi_ext_addr), .ram_addr_o(fmi_ram_addr)
	);

	kexp_walker #(
		.ADDR_W(ADDR_W), .RAM_AW(RAM_AW), .NPAR(NPAR), .NNP(NNP)
	) kexp_i (
		.clk(clk), .rst(rst),
		.start_i(kex_start), .step_i(kex_step),
		.tx_i(tx_i), .x_mem_i(x_mem_i),
		.nif_i(nif), .t_i(t), .ngr_i(ngr), .kex_base_i(kex_base_a),
		.last_o(kex_last), .ext_addr_o(kex_ext_addr), .ram_addr_o(kex_ram_addr)
	);

endmodule

// ==== hw/dma_ctrl.sv ====
`timescale 1ns/1ps

module dma_ctrl
	import dma_pkg::*;
#(
	parameter int DATA_W = 32,
	parameter int ADDR_W = 32,
	parameter int RAM_AW = 12
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start_i,
	input  dma_op_t               op_i,
	input  logic                  mem_valid_i,
	input  logic [DATA_W-1:0]     mem_data_i,
	output logic                  mem_req_o,
	output logic [ADDR_W-1:0]     mem_addr_o,
	output logic                  w_fmi_o,
	output logic                  w_kex_o,
	output logic [RAM_AW-1:0]     ram_addr_o,
	output logic [DATA_W-1:0]     wdata_o,
	output logic                  done_o,
	// Descriptor registers
	output logic                  desc_clr_o,
	output logic                  desc_wr_o,
	input  logic [DESC_IDX_W-1:0] desc_idx_i,
	input  logic                  desc_last_i,
	// Input tile walker
	output logic                  fmi_start_o,
	output logic                  fmi_step_o,
	input  logic                  fmi_last_i,
	input  logic                  fmi_pad_i,
	input  logic [ADDR_W-1:0]     fmi_ext_addr_i,
	input  logic [RAM_AW-1:0]     fmi_ram_addr_i,
	// Expansion kernel walker
	output logic                  kex_start_o,
	output logic                  kex_step_o,
	input  logic                  kex_last_i,
	input  logic [ADDR_W-1:0]     kex_ext_addr_i,
	input  logic [RAM_AW-1:0]     kex_ram_addr_i
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_R_INIT, ST_W_INIT, // Descriptor words
		ST_R_FMI,  ST_W_FMI,  // Input tile pixels
		ST_R_KEXP, ST_W_KEXP, // Expansion kernel words
		ST_FINISHED
	} state_t;

	state_t            state, state_n;
	logic              req_q, req_n;  // Request pulse, one cycle after entering read
	logic [DATA_W-1:0] data_q;        // Word to write
	logic              data_ld;
	logic              data_zero;     // Padding pixel
	logic              accept;        // Start taken this cycle

	assign accept = (state == ST_IDLE) && start_i;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state <= ST_IDLE;
			req_q <= 1'b0;
		end else begin
			state <= state_n;
			req_q <= req_n;
		end
	end

	always_ff @(posedge clk) begin
		if (data_ld)
			data_q <= data_zero ? '0 : mem_data_i;
	end

	always_comb begin
		state_n   = state;
		req_n     = 1'b0;
		data_ld   = 1'b0;
		data_zero = 1'b0;
		case (state)
			ST_IDLE: begin
				if (start_i) begin
					case (op_i)
						OP_LOAD_LAYER: state_n = ST_R_INIT;
						OP_FILL_FMI:   state_n = ST_R_FMI;
						OP_FILL_KEXP:  state_n = ST_R_KEXP;
						default:       state_n = ST_FINISHED; // Unsupported op
					endcase
					req_n = (op_i == OP_LOAD_LAYER) || (op_i == OP_FILL_FMI) ||
						(op_i == OP_FILL_KEXP);
				end
			end
			ST_R_INIT, ST_R_KEXP: begin
				if (mem_valid_i) begin
					state_n = (state == ST_R_INIT) ? ST_W_INIT : ST_W_KEXP;
					data_ld = 1'b1;
				end
			end
			ST_R_FMI: begin
				if (fmi_pad_i) begin // No request went out
					state_n   = ST_W_FMI;
					data_ld   = 1'b1;
					data_zero = 1'b1;
				end else if (mem_valid_i) begin
					state_n = ST_W_FMI;
					data_ld = 1'b1;
				end
			end
			ST_W_INIT: begin
				state_n = desc_last_i ? ST_FINISHED : ST_R_INIT;
				req_n   = !desc_last_i;
			end
			ST_W_FMI: begin
				state_n = fmi_last_i ? ST_FINISHED : ST_R_FMI;
				req_n   = !fmi_last_i;
			end
			ST_W_KEXP: begin
				state_n = kex_last_i ? ST_FINISHED : ST_R_KEXP;
				req_n   = !kex_last_i;
			end
			ST_FINISHED: state_n = ST_IDLE;
			default:     state_n = ST_IDLE;
		endcase
	end

	// Padding pixels never reach memory
	assign mem_req_o = req_q && !((state == ST_R_FMI) && fmi_pad_i);

	assign desc_clr_o  = accept && (op_i == OP_LOAD_LAYER);
	assign fmi_start_o = accept && (op_i == OP_FILL_FMI);
	assign kex_start_o = accept && (op_i == OP_FILL_KEXP);

	// Write strobes double as walker steps
	assign desc_wr_o  = (state == ST_W_INIT);
	assign w_fmi_o    = (state == ST_W_FMI);
	assign w_kex_o    = (state == ST_W_KEXP);
	assign fmi_step_o = w_fmi_o;
	assign kex_step_o = w_kex_o;
	assign done_o     = (state == ST_FINISHED);
	assign wdata_o    = data_q;

	// Address source follows the active operation
	always_comb begin
		case (state)
			ST_R_INIT, ST_W_INIT: begin
				mem_addr_o = ADDR_W'(desc_idx_i); // Descriptor at address 0
				ram_addr_o = '0;
			end
			ST_R_FMI, ST_W_FMI: begin
				mem_addr_o = fmi_ext_addr_i;
				ram_addr_o = fmi_ram_addr_i;
			end
			ST_R_KEXP, ST_W_KEXP: begin
				mem_addr_o = kex_ext_addr_i;
				ram_addr_o = kex_ram_addr_i;
			end
			default: begin
				mem_addr_o = '0;
				ram_addr_o = '0;
			end
		endcase
	end

endmodule

// ==== hw/kexp_walker.sv ====
`timescale 1ns/1ps

module kexp_walker
	import dma_pkg::*;
#(
	parameter int ADDR_W = 32,
	parameter int RAM_AW = 12,
	parameter int NPAR   = 4,
	parameter int NNP    = 4
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              start_i,
	input  logic              step_i,
	input  logic [ADDR_W-1:0] tx_i,       // First intermediate channel
	input  logic [ADDR_W-1:0] x_mem_i,    // Memory offset of that kernel
	input  logic [CH_W-1:0]   nif_i,
	input  logic [EXP_W-1:0]  t_i,
	input  logic [CH_W-1:0]   ngr_i,
	input  logic [ADDR_W-1:0] kex_base_i,
	output logic              last_o,
	output logic [ADDR_W-1:0] ext_addr_o,
	output logic [RAM_AW-1:0] ram_addr_o
);

	localparam int KW = $clog2(NPAR + 1);

	logic [KW-1:0]     k;        // Kernel in this fill, from 1
	logic [ADDR_W-1:0] ch;       // Intermediate channel
	logic [ADDR_W-1:0] mem_ref;  // x_mem_i held for the fill
	logic [ADDR_W-1:0] k_off;    // kernel * size
	logic [ADDR_W-1:0] w_off;    // Word inside kernel
	logic [ADDR_W-1:0] kex_size; // Ngr*NNP words
	logic [ADDR_W-1:0] nintf;    // Nif*t channels
	logic              word_last;
	logic              kern_last;

	assign kex_size = ADDR_W'(ngr_i) * ADDR_W'(NNP);
	assign nintf    = ADDR_W'(nif_i) * ADDR_W'(t_i);

	assign word_last = (w_off == kex_size - ADDR_W'(1));
	assign kern_last = (k == KW'(NPAR)) || (ch == nintf); // Buffer full or no channels left
	assign last_o    = word_last && kern_last;

	assign ext_addr_o = kex_base_i + mem_ref + k_off + w_off;
	assign ram_addr_o = RAM_AW'(k_off + w_off);

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			k       <= '0;
			ch      <= '0;
			mem_ref <= '0;
			k_off   <= '0;
			w_off   <= '0;
		end else if (start_i) begin
			k       <= KW'(1);
			ch      <= tx_i;
			mem_ref <= x_mem_i;
			k_off   <= '0;
			w_off   <= '0;
		end else if (step_i) begin
			if (word_last) begin
				w_off <= '0;
				if (!kern_last) begin
					k     <= k + KW'(1);
					ch    <= ch + ADDR_W'(1);
					k_off <= k_off + kex_size; // Kernels packed back to back
				end
			end else begin
				w_off <= w_off + ADDR_W'(1);
			end
		end
	end

endmodule

// ==== hw/fmi_tile_walker.sv ====
`timescale 1ns/1ps

module fmi_tile_walker
	import dma_pkg::*;
#(
	parameter int ADDR_W = 32,
	parameter int RAM_AW = 12,
	parameter int TIX    = 8,
	parameter int TIY    = 8,
	parameter int KX     = 3,
	parameter int KY     = 3
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              start_i,    // Load counters
	input  logic              step_i,     // Pixel written, advance
	input  logic [ADDR_W-1:0] tx_i,       // First image column of tile
	input  logic [ADDR_W-1:0] ty_i,       // First image row of tile
	input  logic [ADDR_W-1:0] x_mem_i,
	input  logic [ADDR_W-1:0] y_mem_i,
	input  logic [DIM_W-1:0]  nix_i,
	input  logic [DIM_W-1:0]  niy_i,
	input  logic [CH_W-1:0]   nif_i,
	input  logic [ADDR_W-1:0] ifm_base_i,
	output logic              pad_o,
	output logic              last_o,
	output logic [ADDR_W-1:0] ext_addr_o,
	output logic [RAM_AW-1:0] ram_addr_o
);

	localparam int XW = $clog2(TIX + 1);
	localparam int YW = $clog2(TIY + 1);

	localparam logic [ADDR_W-1:0] HALF_KX  = ADDR_W'(KX / 2); // Padded border width
	localparam logic [ADDR_W-1:0] HALF_KY  = ADDR_W'(KY / 2);
	localparam logic [RAM_AW-1:0] RAM_ROW  = RAM_AW'(TIX);
	localparam logic [RAM_AW-1:0] RAM_CHAN = RAM_AW'(TIX * TIY);

	logic [XW-1:0]     x;          // Tile column, from 1
	logic [YW-1:0]     y;          // Tile row, from 1
	logic [CH_W-1:0]   f;          // Channel, from 1
	logic [ADDR_W-1:0] tx, ty;     // Image coordinates incl. border
	logic [ADDR_W-1:0] tx0, ty0;   // Tile origin
	logic [ADDR_W-1:0] x_mem;      // Column offset in memory
	logic [ADDR_W-1:0] y_mem;      // Row offset in memory
	logic [ADDR_W-1:0] f_mem;      // Channel offset in memory
	logic [ADDR_W-1:0] x_ref, y_ref;
	logic [RAM_AW-1:0] x_ram, y_ram, f_ram;

	logic [ADDR_W-1:0] nix_a, niy_a;
	logic [ADDR_W-1:0] chan_size;  // Nix*Niy words per channel
	logic              row_end;
	logic              col_end;

	assign nix_a     = ADDR_W'(nix_i);
	assign niy_a     = ADDR_W'(niy_i);
	assign chan_size = nix_a * niy_a;

	assign row_end = (x == XW'(TIX)) || (tx == nix_a + HALF_KX);
	assign col_end = (y == YW'(TIY)) || (ty == niy_a + HALF_KY);

	// Outside the image, write a zero
	assign pad_o  = (tx == '0) || (ty == '0) || (tx > nix_a) || (ty > niy_a);
	assign last_o = row_end && col_end && (f == nif_i);

	assign ext_addr_o = ifm_base_i + x_mem + y_mem + f_mem;
	assign ram_addr_o = x_ram + y_ram + f_ram;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			x     <= '0;
			y     <= '0;
			f     <= '0;
			tx    <= '0;
			ty    <= '0;
			tx0   <= '0;
			ty0   <= '0;
			x_mem <= '0;
			y_mem <= '0;
			f_mem <= '0;
			x_ref <= '0;
			y_ref <= '0;
			x_ram <= '0;
			y_ram <= '0;
			f_ram <= '0;
		end else if (start_i) begin
			x     <= XW'(1);
			y     <= YW'(1);
			f     <= CH_W'(1);
			tx    <= tx_i;
			ty    <= ty_i;
			tx0   <= tx_i;
			ty0   <= ty_i;
			x_mem <= x_mem_i;
			y_mem <= y_mem_i;
			x_ref <= x_mem_i;
			y_ref <= y_mem_i;
			f_mem <= '0;
			x_ram <= '0;
			y_ram <= '0;
			f_ram <= '0;
		end else if (step_i) begin
			if (row_end) begin
				x     <= XW'(1); // Back to first column
				tx    <= tx0;
				x_ram <= '0;
				x_mem <= x_ref;
				if (col_end) begin
					y     <= YW'(1);
					ty    <= ty0;
					y_ram <= '0;
					y_mem <= y_ref;
					if (f != nif_i) begin
						f     <= f + CH_W'(1);
						f_ram <= f_ram + RAM_CHAN; // Next channel slot in RAM
						f_mem <= f_mem + chan_size;
					end
				end else begin
					y     <= y + YW'(1);
					ty    <= ty + ADDR_W'(1);
					y_ram <= y_ram + RAM_ROW;
					if (ty != '0)
						y_mem <= y_mem + nix_a; // Top border row has no memory row
				end
			end else begin
				x     <= x + XW'(1);
				tx    <= tx + ADDR_W'(1);
				x_ram <= x_ram + RAM_AW'(1);
				if (!pad_o)
					x_mem <= x_mem + ADDR_W'(1); // Only real pixels consume memory
			end
		end
	end

endmodule

// ==== hw/layer_desc_regs.sv ====
`timescale 1ns/1ps

module layer_desc_regs
	import dma_pkg::*;
#(
	parameter int DATA_W = 32
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   desc_clr_i,  // Layer load start
	input  logic                   desc_wr_i,   // One descriptor word ready
	input  logic [DATA_W-1:0]      wdata_i,
	output logic [DESC_IDX_W-1:0]  desc_idx_o,
	output logic                   desc_last_o,
	output logic [DIM_W-1:0]       nix_o,
	output logic [DIM_W-1:0]       niy_o,
	output logic [CH_W-1:0]        nif_o,
	output logic [EXP_W-1:0]       t_o,
	output logic [CH_W-1:0]        ngr_o,
	output logic [DATA_W-1:0]      ifm_base_o,
	output logic [DATA_W-1:0]      kex_base_o,
	output logic [CONV_INFO_W-1:0] conv_info_o
);

	logic [DESC_IDX_W-1:0] idx; // Word being received
	logic [CH_W-1:0]       nof;
	logic [CH_W-1:0]       ngrint;
	logic                  s;   // Stride flag, only reported

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			idx        <= '0;
			nix_o      <= '0;
			niy_o      <= '0;
			t_o        <= '0;
			s          <= 1'b0;
			nif_o      <= '0;
			nof        <= '0;
			ngr_o      <= '0;
			ngrint     <= '0;
			ifm_base_o <= '0;
			kex_base_o <= '0;
		end else if (desc_clr_i) begin
			idx <= '0; // New layer, restart at word 0
		end else if (desc_wr_i) begin
			idx <= idx + DESC_IDX_W'(1);
			// Route word to its fields
			case (idx)
				DESC_DIMS: begin
					nix_o <= wdata_i[0 +: DIM_W];
					niy_o <= wdata_i[W0_NIY_LSB +: DIM_W];
					t_o   <= wdata_i[W0_T_LSB +: EXP_W];
					s     <= wdata_i[W0_S_BIT];
				end
				DESC_CHAN: begin
					nif_o <= wdata_i[0 +: CH_W];
					nof   <= wdata_i[W1_NOF_LSB +: CH_W];
				end
				DESC_GROUP: begin
					ngr_o  <= wdata_i[0 +: CH_W];
					ngrint <= wdata_i[W2_NGRINT_LSB +: CH_W];
				end
				DESC_IFM_BASE:  ifm_base_o <= wdata_i;
				DESC_KEXP_BASE: kex_base_o <= wdata_i;
				default: ; // Output, PW and DW bases not kept
			endcase
		end
	end

	assign desc_idx_o  = idx;
	assign desc_last_o = (idx == DESC_IDX_W'(LAYER_DESC_WORDS - 1));

	// Ngrint | Ngr | S | t | Nof | Nif | Niy | Nix from msb down
	assign conv_info_o = {ngrint, ngr_o, s, t_o, nof, nif_o, niy_o, nix_o};

endmodule

// ==== hw/dma_pkg.sv ====
package dma_pkg;

	// DMA operation codes, other codes end at once
	typedef enum logic [2:0] {
		OP_LOAD_LAYER = 3'd0, // Layer descriptor read
		OP_FILL_FMI   = 3'd1, // Input tile fill
		OP_FILL_KEXP  = 3'd2  // 1x1 expansion kernel fill
	} dma_op_t;

	// Field widths
	localparam int DIM_W = 8;  // Spatial dimension
	localparam int CH_W  = 11; // Channel or group count
	localparam int EXP_W = 3;  // Expansion factor

	// Layer descriptor in external memory
	localparam int LAYER_DESC_WORDS = 8;
	localparam int DESC_IDX_W       = $clog2(LAYER_DESC_WORDS);

	localparam logic [DESC_IDX_W-1:0] DESC_DIMS      = 3'd0; // Nix, Niy, t, S
	localparam logic [DESC_IDX_W-1:0] DESC_CHAN      = 3'd1; // Nif, Nof
	localparam logic [DESC_IDX_W-1:0] DESC_GROUP     = 3'd2; // Ngr, Ngrint
	localparam logic [DESC_IDX_W-1:0] DESC_IFM_BASE  = 3'd3;
	localparam logic [DESC_IDX_W-1:0] DESC_KEXP_BASE = 3'd5;

	// Bit positions inside descriptor words
	localparam int W0_NIY_LSB    = 8;
	localparam int W0_T_LSB      = 16;
	localparam int W0_S_BIT      = 19;
	localparam int W1_NOF_LSB    = 12;
	localparam int W2_NGRINT_LSB = 12;

	// Packed layer info word for the main controller
	localparam int CONV_INFO_W = 64;

endpackage
